// File: compile.f
design/adc_ts_pkg.sv
design/adc_ts_reg_if.sv
design/adc_ts_sampler.sv
design/adc_ts_rx_channel.sv
design/adc_ts_top.sv
dv/adc_ts_adc_model.sv
dv/adc_ts_tb.sv

// File: design/adc_ts_pkg.sv
// ADC timestamp capture subsystem, shared definitions
// Register map, scan control word, receive channel config and status,
// and the tagged sample word written to L2
`default_nettype none

package adc_ts_pkg;

    // L2 byte address width
    localparam int L2_AWIDTH_NOAL = 12;

    // ADC result and channel field widths
    localparam int ADC_DW = 12;
    localparam int NUM_CH = 8;
    localparam int CH_W   = 3;

    // Transfer size field as seen by software
    localparam int RX_SIZE_W = 16;

    // Sample period and timestamp widths
    localparam int PERIOD_W = 16;
    localparam int TS_W     = 16;

    typedef enum logic [4:0] {
        RX_SADDR  = 5'd0,
        RX_SIZE   = 5'd1,
        RX_CFG    = 5'd2,
        RX_INTCFG = 5'd3,
        CR_ADC    = 5'd4
    } reg_addr_e;

    // Scan control word, run at bit 24
    typedef struct packed {
        logic [2:0]          rsvd;
        logic                run;
        logic [PERIOD_W-1:0] period;
        logic [NUM_CH-1:0]   mask;
    } adc_cr_t;

    typedef struct packed {
        logic [L2_AWIDTH_NOAL-1:0] saddr;
        logic [RX_SIZE_W-1:0]      size;
        logic                      continuous;
    } rx_cfg_t;

    typedef struct packed {
        logic [L2_AWIDTH_NOAL-1:0] curr_addr;
        logic [RX_SIZE_W-1:0]      bytes_left;
        logic                      active;
        logic                      pending;
    } rx_status_t;

    // One 32-bit word per conversion
    typedef struct packed {
        logic [TS_W-1:0]   ts;
        logic [CH_W-1:0]   chan;
        logic              zero;
        logic [ADC_DW-1:0] data;
    } adc_sample_t;

    typedef enum logic [1:0] {
        SC_IDLE  = 2'd0,
        SC_START = 2'd1,
        SC_WAIT  = 2'd2
    } scan_state_e;

endpackage

`default_nettype wire

// File: design/adc_ts_reg_if.sv
// ADC timestamp capture, configuration register block
// Decodes writes from the config bus, issues enable, clear and
// control-write strobes, and returns read data combinationally
`timescale 1ns/1ps
`default_nettype none

module adc_ts_reg_if
    import adc_ts_pkg::*;
#(
    parameter int TRANS_SIZE = 16
) (
    input  wire logic        clk_i,
    input  wire logic        rstn_i,

    input  wire logic [31:0] cfg_data_i,
    input  wire logic [4:0]  cfg_addr_i,
    input  wire logic        cfg_valid_i,
    input  wire logic        cfg_rwn_i,
    output logic      [31:0] cfg_data_o,
    output logic             cfg_ready_o,

    output rx_cfg_t          rx_cfg_o,
    output logic             rx_en_o,
    output logic             rx_clr_o,
    input  rx_status_t       rx_status_i,

    output adc_cr_t          adc_cr_o,
    output logic             cr_wr_o
);

    logic [L2_AWIDTH_NOAL-1:0] r_rx_startaddr;
    logic [TRANS_SIZE-1:0]     r_rx_size;
    logic                      r_rx_continuous;
    logic                      r_rx_en;
    logic                      r_rx_clr;
    adc_cr_t                   r_adc_cr;
    logic                      r_cr_wr;

    logic                      s_wr;
    logic                      s_rd;
    reg_addr_e                 s_addr;

    assign s_wr   = cfg_valid_i & ~cfg_rwn_i;
    assign s_rd   = cfg_valid_i &  cfg_rwn_i;
    assign s_addr = reg_addr_e'(cfg_addr_i);

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_rx_startaddr  <= '0;
            r_rx_size       <= '0;
            r_rx_continuous <= 1'b0;
            r_rx_en         <= 1'b0;
            r_rx_clr        <= 1'b0;
            r_adc_cr        <= '0;
            r_cr_wr         <= 1'b0;
        end
        else
        begin
            // Strobes last a single cycle
            r_rx_en  <= 1'b0;
            r_rx_clr <= 1'b0;
            r_cr_wr  <= 1'b0;

            if (s_wr)
            begin
                case (s_addr)
                    RX_SADDR:
                        r_rx_startaddr <= cfg_data_i[L2_AWIDTH_NOAL-1:0];
                    RX_SIZE:
                        r_rx_size <= cfg_data_i[TRANS_SIZE-1:0];
                    RX_CFG:
                    begin
                        r_rx_clr        <= cfg_data_i[5];
                        r_rx_en         <= cfg_data_i[4];
                        r_rx_continuous <= cfg_data_i[0];
                    end
                    CR_ADC:
                    begin
                        r_adc_cr <= adc_cr_t'(cfg_data_i[$bits(adc_cr_t)-1:0]);
                        r_cr_wr  <= 1'b1;
                    end
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    assign rx_cfg_o.saddr      = r_rx_startaddr;
    assign rx_cfg_o.size       = RX_SIZE_W'(r_rx_size);
    assign rx_cfg_o.continuous = r_rx_continuous;
    assign rx_en_o             = r_rx_en;
    assign rx_clr_o            = r_rx_clr;
    assign adc_cr_o            = r_adc_cr;
    assign cr_wr_o             = r_cr_wr;

    // Read-back mixes stored fields with live channel status
    always_comb
    begin
        cfg_data_o = '0;
        if (s_rd)
        begin
            case (s_addr)
                RX_SADDR:
                    cfg_data_o = 32'(rx_status_i.curr_addr);
                RX_SIZE:
                    cfg_data_o = 32'(rx_status_i.bytes_left);
                RX_CFG:
                    cfg_data_o = {26'h0, rx_status_i.pending, rx_status_i.active,
                                  1'b0, 2'b10, r_rx_continuous};
                CR_ADC:
                    cfg_data_o = 32'(r_adc_cr);
                default:
                    cfg_data_o = '0;
            endcase
        end
    end

    assign cfg_ready_o = 1'b1;

    // Only one register write per cycle reaches the strobes
    a_strobe_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(rx_en_o && cr_wr_o));

endmodule

`default_nettype wire

// File: design/adc_ts_rx_channel.sv
// ADC timestamp capture, receive DMA channel
// Writes tagged samples to L2 as a linear buffer, single-shot or
// wrapping, with one queued transfer and a clear
`timescale 1ns/1ps
`default_nettype none

module adc_ts_rx_channel
    import adc_ts_pkg::*;
#(
    parameter int TRANS_SIZE = 16
) (
    input  wire logic                 clk_i,
    input  wire logic                 rstn_i,

    input  rx_cfg_t                   rx_cfg_i,
    input  wire logic                 rx_en_i,
    input  wire logic                 rx_clr_i,

    input  wire logic                 sample_valid_i,
    input  adc_sample_t               sample_i,

    output rx_status_t                rx_status_o,

    output logic                      l2_wr_o,
    output logic [L2_AWIDTH_NOAL-1:0] l2_addr_o,
    output logic [31:0]               l2_data_o
);

    logic [L2_AWIDTH_NOAL-1:0] r_curr_addr;
    logic [TRANS_SIZE-1:0]     r_bytes_left;
    logic                      r_active;
    logic                      r_pending;
    logic                      r_l2_wr;
    logic [L2_AWIDTH_NOAL-1:0] r_l2_addr;
    logic [31:0]               r_l2_data;

    logic                      s_accept;
    logic                      s_last;

    assign s_accept = sample_valid_i && r_active && !rx_clr_i;
    // Last word of the buffer
    assign s_last   = (r_bytes_left <= TRANS_SIZE'(4));

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_curr_addr  <= '0;
            r_bytes_left <= '0;
            r_active     <= 1'b0;
            r_pending    <= 1'b0;
            r_l2_wr      <= 1'b0;
            r_l2_addr    <= '0;
            r_l2_data    <= '0;
        end
        else
        begin
            r_l2_wr <= s_accept;

            if (rx_clr_i)
            begin
                r_active  <= 1'b0;
                r_pending <= 1'b0;
            end
            else
            begin
                if (s_accept)
                begin
                    r_l2_addr <= r_curr_addr;
                    r_l2_data <= sample_i;
                    if (!s_last)
                    begin
                        r_curr_addr  <= r_curr_addr + L2_AWIDTH_NOAL'(4);
                        r_bytes_left <= r_bytes_left - TRANS_SIZE'(4);
                    end
                    else if (rx_cfg_i.continuous || r_pending)
                    begin
                        r_curr_addr  <= rx_cfg_i.saddr;
                        r_bytes_left <= TRANS_SIZE'(rx_cfg_i.size);
                        r_pending    <= 1'b0;
                    end
                    else
                    begin
                        r_bytes_left <= '0;
                        r_active     <= 1'b0;
                    end
                end

                // A new enable queues behind a running transfer
                if (rx_en_i)
                begin
                    if (r_active)
                    begin
                        r_pending <= 1'b1;
                    end
                    else
                    begin
                        r_curr_addr  <= rx_cfg_i.saddr;
                        r_bytes_left <= TRANS_SIZE'(rx_cfg_i.size);
                        r_active     <= 1'b1;
                    end
                end
            end
        end
    end

    assign rx_status_o.curr_addr  = r_curr_addr;
    assign rx_status_o.bytes_left = RX_SIZE_W'(r_bytes_left);
    assign rx_status_o.active     = r_active;
    assign rx_status_o.pending    = r_pending;

    assign l2_wr_o   = r_l2_wr;
    assign l2_addr_o = r_l2_addr;
    assign l2_data_o = r_l2_data;

    // Every L2 write belongs to a transfer that was running the cycle before
    a_wr_active: assert property (@(posedge clk_i) disable iff (!rstn_i)
        l2_wr_o |-> $past(r_active));

endmodule

`default_nettype wire

// File: design/adc_ts_sampler.sv
// ADC timestamp capture, scan sampler
// Period timer with tick counter, channel scan over the enable mask,
// one ADC conversion at a time, each result tagged with its tick
`timescale 1ns/1ps
`default_nettype none

module adc_ts_sampler
    import adc_ts_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rstn_i,

    input  adc_cr_t                adc_cr_i,
    input  wire logic              cr_wr_i,

    output logic                   adc_soc_o,
    output logic      [CH_W-1:0]   adc_chan_o,
    input  wire logic              adc_eoc_i,
    input  wire logic [ADC_DW-1:0] adc_data_i,

    output logic                   sample_valid_o,
    output adc_sample_t            sample_o
);

    logic [PERIOD_W-1:0] r_period_cnt;
    logic [TS_W-1:0]     r_ts_cnt;
    logic [TS_W-1:0]     r_scan_ts;
    logic [NUM_CH-1:0]   r_pend;
    logic [CH_W-1:0]     r_chan;
    scan_state_e         r_state;
    logic                r_sample_valid;
    adc_sample_t         r_sample;

    logic                s_tick;
    logic [CH_W-1:0]     s_next_chan;

    assign s_tick = adc_cr_i.run && !cr_wr_i && (r_period_cnt == adc_cr_i.period);

    // Lowest channel still waiting in this scan
    always_comb
    begin
        s_next_chan = '0;
        for (int i = NUM_CH - 1; i >= 0; i--)
        begin
            if (r_pend[i])
                s_next_chan = CH_W'(i);
        end
    end

    // Period timer and tick count, both restart on a control write
    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_period_cnt <= '0;
            r_ts_cnt     <= '0;
        end
        else if (cr_wr_i || !adc_cr_i.run)
        begin
            r_period_cnt <= '0;
            if (cr_wr_i)
                r_ts_cnt <= '0;
        end
        else if (s_tick)
        begin
            r_period_cnt <= '0;
            r_ts_cnt     <= r_ts_cnt + 1'b1;
        end
        else
        begin
            r_period_cnt <= r_period_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_state        <= SC_IDLE;
            r_scan_ts      <= '0;
            r_pend         <= '0;
            r_chan         <= '0;
            r_sample_valid <= 1'b0;
            r_sample       <= '0;
        end
        else
        begin
            r_sample_valid <= 1'b0;
            case (r_state)
                SC_IDLE:
                begin
                    // A tick during a running scan is simply missed
                    if (s_tick && (adc_cr_i.mask != '0))
                    begin
                        r_scan_ts <= r_ts_cnt;
                        r_pend    <= adc_cr_i.mask;
                        r_state   <= SC_START;
                    end
                end
                SC_START:
                begin
                    r_chan  <= s_next_chan;
                    r_pend  <= r_pend & ~(NUM_CH'(1) << s_next_chan);
                    r_state <= SC_WAIT;
                end
                SC_WAIT:
                begin
                    if (adc_eoc_i)
                    begin
                        r_sample_valid <= 1'b1;
                        r_sample.ts    <= r_scan_ts;
                        r_sample.chan  <= r_chan;
                        r_sample.zero  <= 1'b0;
                        r_sample.data  <= adc_data_i;
                        r_state        <= (r_pend != '0) ? SC_START : SC_IDLE;
                    end
                end
                default:
                    r_state <= SC_IDLE;
            endcase
        end
    end

    assign adc_soc_o      = (r_state == SC_START);
    assign adc_chan_o     = s_next_chan;
    assign sample_valid_o = r_sample_valid;
    assign sample_o       = r_sample;

    // No new start until the ADC has answered the previous one
    a_one_conv: assert property (@(posedge clk_i) disable iff (!rstn_i)
        adc_soc_o |=> (!adc_soc_o until_with adc_eoc_i));

endmodule

`default_nettype wire

// File: design/adc_ts_top.sv
// ADC timestamp capture subsystem, top level
// Register block, scan sampler and receive DMA channel
`timescale 1ns/1ps
`default_nettype none

module adc_ts_top
    import adc_ts_pkg::*;
#(
    parameter int TRANS_SIZE = 16
) (
    input  wire logic                      clk_i,
    input  wire logic                      rstn_i,

    input  wire logic [31:0]               cfg_data_i,
    input  wire logic [4:0]                cfg_addr_i,
    input  wire logic                      cfg_valid_i,
    input  wire logic                      cfg_rwn_i,
    output logic      [31:0]               cfg_data_o,
    output logic                           cfg_ready_o,

    output logic                           adc_soc_o,
    output logic      [CH_W-1:0]           adc_chan_o,
    input  wire logic                      adc_eoc_i,
    input  wire logic [ADC_DW-1:0]         adc_data_i,

    output logic                           l2_wr_o,
    output logic      [L2_AWIDTH_NOAL-1:0] l2_addr_o,
    output logic      [31:0]               l2_data_o
);

    rx_cfg_t     s_rx_cfg;
    rx_status_t  s_rx_status;
    logic        s_rx_en;
    logic        s_rx_clr;
    adc_cr_t     s_adc_cr;
    logic        s_cr_wr;
    logic        s_sample_valid;
    adc_sample_t s_sample;

    adc_ts_reg_if #(
        .TRANS_SIZE (TRANS_SIZE)
    ) i_reg_if (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cfg_data_i  (cfg_data_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_valid_i (cfg_valid_i),
        .cfg_rwn_i   (cfg_rwn_i),
        .cfg_data_o  (cfg_data_o),
        .cfg_ready_o (cfg_ready_o),
        .rx_cfg_o    (s_rx_cfg),
        .rx_en_o     (s_rx_en),
        .rx_clr_o    (s_rx_clr),
        .rx_status_i (s_rx_status),
        .adc_cr_o    (s_adc_cr),
        .cr_wr_o     (s_cr_wr)
    );

    adc_ts_sampler i_sampler (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .adc_cr_i       (s_adc_cr),
        .cr_wr_i        (s_cr_wr),
        .adc_soc_o      (adc_soc_o),
        .adc_chan_o     (adc_chan_o),
        .adc_eoc_i      (adc_eoc_i),
        .adc_data_i     (adc_data_i),
        .sample_valid_o (s_sample_valid),
        .sample_o       (s_sample)
    );

    adc_ts_rx_channel #(
        .TRANS_SIZE (TRANS_SIZE)
    ) i_rx_channel (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .rx_cfg_i       (s_rx_cfg),
        .rx_en_i        (s_rx_en),
        .rx_clr_i       (s_rx_clr),
        .sample_valid_i (s_sample_valid),
        .sample_i       (s_sample),
        .rx_status_o    (s_rx_status),
        .l2_wr_o        (l2_wr_o),
        .l2_addr_o      (l2_addr_o),
        .l2_data_o      (l2_data_o)
    );

endmodule

`default_nettype wire

// File: dv/adc_ts_adc_model.sv
// Behavioral ADC for the timestamp capture testbench
// Answers each start of conversion after 2 to 9 cycles with
// data equal to channel * 256 plus that channel's conversion count
`timescale 1ns/1ps
`default_nettype none

module adc_ts_adc_model
    import adc_ts_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rstn_i,
    input  wire logic              soc_i,
    input  wire logic [CH_W-1:0]   chan_i,
    output logic                   eoc_o,
    output logic      [ADC_DW-1:0] data_o
);

    integer          seed = 32'he35e_0d82;
    int              conv_cnt [NUM_CH];
    int              remaining;
    logic            busy;
    logic [CH_W-1:0] chan_q;

    always @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            eoc_o     <= 1'b0;
            data_o    <= '0;
            busy      <= 1'b0;
            remaining <= 0;
            chan_q    <= '0;
            for (int i = 0; i < NUM_CH; i++)
                conv_cnt[i] <= 0;
        end
        else
        begin
            eoc_o <= 1'b0;
            if (soc_i)
            begin
                busy      <= 1'b1;
                chan_q    <= chan_i;
                // Counts down to the cycle before the answer
                remaining <= 1 + ($random(seed) & 7);
            end
            else if (busy)
            begin
                if (remaining == 1)
                begin
                    eoc_o            <= 1'b1;
                    data_o           <= ADC_DW'(int'(chan_q) * 256 + conv_cnt[chan_q] % 256);
                    conv_cnt[chan_q] <= conv_cnt[chan_q] + 1;
                    busy             <= 1'b0;
                end
                else
                begin
                    remaining <= remaining - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/adc_ts_tb.sv
// Testbench for the ADC timestamp capture subsystem
// Programs scans and receive buffers from a case table, predicts every
// L2 write from the ADC data rule and the buffer rules, and checks
// register read-back, pending, clear and dropped samples
`timescale 1ns/1ps
`default_nettype none

module adc_ts_tb
    import adc_ts_pkg::*;
();

    localparam int NUM_CASES = 5;

    typedef struct packed {
        logic [7:0]  mask;
        logic [15:0] period;
        logic [11:0] saddr;
        logic [15:0] size;
        logic        cont;
        logic        queue;
        logic        clr;
        logic [7:0]  nwr;
    } case_t;

    logic                      clk_i = 1'b0;
    logic                      rstn_i;
    logic                      cfg_valid;
    logic                      cfg_rwn;
    logic [4:0]                cfg_addr;
    logic [31:0]               cfg_wdata;
    logic [31:0]               cfg_rdata;
    logic                      cfg_ready;
    logic                      adc_soc;
    logic [CH_W-1:0]           adc_chan;
    logic                      adc_eoc;
    logic [ADC_DW-1:0]         adc_data;
    logic                      l2_wr;
    logic [L2_AWIDTH_NOAL-1:0] l2_addr;
    logic [31:0]               l2_data;

    case_t                     cases [NUM_CASES];
    int                        conv_cnt [NUM_CH];
    longint                    wd_limit;

    // Mask of the running scan, zero while no scan may start
    logic [7:0]                scan_mask = '0;
    int                        soc_cnt = 0;
    logic [1:0]                eoc_hist = '0;

    always #4 clk_i = ~clk_i;

    adc_ts_top #(
        .TRANS_SIZE (16)
    ) i_dut (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cfg_data_i  (cfg_wdata),
        .cfg_addr_i  (cfg_addr),
        .cfg_valid_i (cfg_valid),
        .cfg_rwn_i   (cfg_rwn),
        .cfg_data_o  (cfg_rdata),
        .cfg_ready_o (cfg_ready),
        .adc_soc_o   (adc_soc),
        .adc_chan_o  (adc_chan),
        .adc_eoc_i   (adc_eoc),
        .adc_data_i  (adc_data),
        .l2_wr_o     (l2_wr),
        .l2_addr_o   (l2_addr),
        .l2_data_o   (l2_data)
    );

    adc_ts_adc_model i_adc (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .soc_i  (adc_soc),
        .chan_i (adc_chan),
        .eoc_o  (adc_eoc),
        .data_o (adc_data)
    );

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp)
        begin
            $display("** Error at %t: %s = 0x%0h, expected 0x%0h", $time, name, act, exp);
            abort_run();
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk_i);
        cfg_valid <= 1'b1;
        cfg_rwn   <= 1'b0;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk_i);
        cfg_valid <= 1'b0;
    endtask

    // Read data is combinational, sampled mid-cycle
    task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
        @(posedge clk_i);
        cfg_valid <= 1'b1;
        cfg_rwn   <= 1'b1;
        cfg_addr  <= addr;
        @(negedge clk_i);
        data = cfg_rdata;
        @(posedge clk_i);
        cfg_valid <= 1'b0;
    endtask

    task automatic expect_reg(input logic [4:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        read_reg(addr, rd);
        check_value($sformatf("cfg_data_o at addr %0d", addr), rd, exp);
    endtask

    // RX_CFG read-back with the word datasize in bits 2:1
    function automatic logic [31:0] rx_cfg_read(input logic pending, input logic active,
                                                input logic cont);
        logic [31:0] v;
        v    = 32'h4;
        v[5] = pending;
        v[4] = active;
        v[0] = cont;
        return v;
    endfunction

    function automatic int count_bits(input logic [7:0] mask);
        int n;
        n = 0;
        for (int b = 0; b < NUM_CH; b++)
            n += mask[b];
        return n;
    endfunction

    // k-th enabled channel in ascending order
    function automatic int nth_chan(input logic [7:0] mask, input int k);
        int seen;
        seen = 0;
        for (int b = 0; b < NUM_CH; b++)
        begin
            if (mask[b])
            begin
                if (seen == k)
                    return b;
                seen++;
            end
        end
        return 0;
    endfunction

    // Scan order of conversion starts and eoc to L2 write latency
    always @(negedge clk_i)
    begin
        if (count_bits(scan_mask) == 0)
            check_value("adc_soc_o", 32'(adc_soc), 32'h0);
        else if (adc_soc)
        begin
            check_value("adc_chan_o", 32'(adc_chan),
                        32'(nth_chan(scan_mask, soc_cnt % count_bits(scan_mask))));
            soc_cnt++;
        end
        if (l2_wr)
            check_value("adc_eoc_i two cycles before l2_wr_o", 32'(eoc_hist[1]), 32'h1);
        eoc_hist = {eoc_hist[0], adc_eoc};
    end

    task automatic wait_l2_write(input int limit);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!l2_wr)
        begin
            if (n >= limit)
            begin
                $display("Error at %t: no L2 write within %0d cycles", $time, limit);
                abort_run();
            end
            else
            begin
                n++;
                @(negedge clk_i);
            end
        end
    endtask

    // Lets nconv conversions complete while no L2 write may occur
    task automatic watch_no_write(input int nconv, input int limit);
        int seen;
        int n;
        seen = 0;
        n    = 0;
        while (seen < nconv)
        begin
            if (n > limit)
            begin
                $display("Error at %t: ADC did not finish %0d conversions in %0d cycles",
                         $time, nconv, limit);
                abort_run();
            end
            else
            begin
                @(negedge clk_i);
                check_value("l2_wr_o", 32'(l2_wr), 32'h0);
                if (adc_eoc)
                    seen++;
                n++;
            end
        end
        // Last sample would reach L2 two cycles after its eoc
        repeat (3)
        begin
            @(negedge clk_i);
            check_value("l2_wr_o", 32'(l2_wr), 32'h0);
        end
    endtask

    task automatic check_reset_state();
        for (int a = 0; a < 32; a++)
        begin
            expect_reg(5'(a), (a == RX_CFG) ? 32'h4 : 32'h0);
            @(negedge clk_i);
            check_value("l2_wr_o", 32'(l2_wr), 32'h0);
            check_value("adc_soc_o", 32'(adc_soc), 32'h0);
        end
        check_value("cfg_ready_o", 32'(cfg_ready), 32'h1);
    endtask

    task automatic check_registers();
        // Run bit clear so no scan starts
        write_reg(CR_ADC, 32'hFEFF_A5C3);
        expect_reg(CR_ADC, 32'hFEFF_A5C3 & 32'h0FFF_FFFF);
        write_reg(CR_ADC, 32'h0);
        write_reg(RX_SADDR, 32'h1234_5ABC);
        write_reg(RX_SIZE, 32'hABCD_0100);
        write_reg(RX_INTCFG, 32'hFFFF_FFFF);
        write_reg(RX_CFG, 32'h10);
        expect_reg(RX_SADDR, 32'h0000_0ABC);
        expect_reg(RX_SIZE, 32'h0000_0100);
        expect_reg(RX_CFG, 32'h14);
        expect_reg(RX_INTCFG, 32'h0);
        expect_reg(5'd9, 32'h0);
        write_reg(RX_CFG, 32'h20);
        expect_reg(RX_CFG, 32'h4);
    endtask

    task automatic run_case(input case_t c);
        int          p;
        int          ch;
        logic [11:0] addr;
        logic [15:0] left;
        logic        active;
        logic        pending;
        logic [31:0] rd;
        logic [31:0] exp_word;

        p       = count_bits(c.mask);
        addr    = c.saddr;
        left    = c.size;
        active  = 1'b1;
        pending = 1'b0;
        write_reg(RX_SADDR, 32'(c.saddr));
        write_reg(RX_SIZE, 32'(c.size));
        write_reg(RX_CFG, {27'h0, 1'b1, 3'h0, c.cont});
        scan_mask = c.mask;
        soc_cnt   = 0;
        write_reg(CR_ADC, {7'h0, 1'b1, c.period, c.mask});
        for (int i = 0; i < c.nwr; i++)
        begin
            wait_l2_write(int'(c.period) + 100);
            ch       = nth_chan(c.mask, i % p);
            exp_word = {16'(i / p), 3'(ch), 1'b0, 12'(ch * 256 + conv_cnt[ch] % 256)};
            conv_cnt[ch] = conv_cnt[ch] + 1;
            check_value("l2_addr_o", 32'(l2_addr), 32'(addr));
            check_value("l2_data_o", l2_data, exp_word);
            // Step through the buffer, reload on wrap or pending
            if (left > 16'd4)
            begin
                addr = addr + 12'd4;
                left = left - 16'd4;
            end
            else if (c.cont || pending)
            begin
                addr    = c.saddr;
                left    = c.size;
                pending = 1'b0;
            end
            else
            begin
                left   = '0;
                active = 1'b0;
            end
            if (c.queue && i == 0)
            begin
                write_reg(RX_CFG, {27'h0, 1'b1, 3'h0, c.cont});
                pending = 1'b1;
                read_reg(RX_CFG, rd);
                check_value("RX_CFG pending bit", 32'(rd[5]), 32'h1);
            end
        end
        if (c.clr)
        begin
            write_reg(RX_CFG, {26'h0, 1'b1, 4'h0, c.cont});
            active  = 1'b0;
            pending = 1'b0;
        end
        if (active)
            write_reg(CR_ADC, 32'h0);
        expect_reg(RX_CFG, rx_cfg_read(pending, active, c.cont));
        expect_reg(RX_SIZE, 32'(left));
        if (!active)
        begin
            // Next scan still converts but nothing reaches L2
            watch_no_write(p, int'(c.period) + 100);
            for (int k = 0; k < p; k++)
            begin
                ch = nth_chan(c.mask, k);
                conv_cnt[ch] = conv_cnt[ch] + 1;
            end
            write_reg(CR_ADC, 32'h0);
        end
        write_reg(RX_CFG, 32'h20);
        scan_mask = '0;
    endtask

    initial
    begin
        $timeformat(-9, 0, " ns", 0);
        rstn_i    = 1'b0;
        cfg_valid = 1'b0;
        cfg_rwn   = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        for (int i = 0; i < NUM_CH; i++)
            conv_cnt[i] = 0;

        // mask, period, start address, size, continuous, queue, clear, writes
        cases[0] = {8'h05, 16'd63, 12'h100, 16'd24, 1'b0, 1'b0, 1'b0, 8'd6};
        cases[1] = {8'h03, 16'd63, 12'h200, 16'd8,  1'b1, 1'b0, 1'b0, 8'd6};
        cases[2] = {8'h01, 16'd47, 12'h300, 16'd12, 1'b0, 1'b1, 1'b0, 8'd5};
        cases[3] = {8'h02, 16'd47, 12'h400, 16'd16, 1'b1, 1'b0, 1'b1, 8'd2};
        cases[4] = {8'h8C, 16'd79, 12'hFF0, 16'd24, 1'b0, 1'b0, 1'b0, 8'd6};

        // Three spare periods per case for setup and the idle scan
        wd_limit = 20000;
        for (int i = 0; i < NUM_CASES; i++)
            wd_limit += (longint'(cases[i].nwr) + 3) * (longint'(cases[i].period) + 1) * 8;
        fork
            begin
                #(wd_limit);
                $display("Error at %t: test timed out", $time);
                abort_run();
            end
        join_none

        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;
        check_reset_state();
        check_registers();
        for (int i = 0; i < NUM_CASES; i++)
            run_case(cases[i]);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
